/* list.f */
verilog/cpu_pkg.sv
verilog/mem_wb_if.sv
verilog/mem_stage.sv
verilog/mem_wb_reg.sv
verilog/wb_stage.sv
verilog/arch_regs.sv
verilog/backend_top.sv
tests/backend_asserts.sv
tests/tb_backend.sv

/* run.sh */
#!/bin/sh
# Build and run the backend testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_backend -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_backend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
exit 1

/* tests/backend_asserts.sv */
// backend_asserts: concurrent checks on the mem/wb register, bound into mem_wb_reg.
`default_nettype none
`timescale 1ns/100ps

module backend_asserts (
    input logic                           clk,
    input logic                           rst,
    input logic                           stall,
    input logic                           flush,
    input logic [cpu_pkg::ADDR_W-1:0]     pc,
    input logic [cpu_pkg::DATA_W-1:0]     alures,
    input logic                           wreg,
    input logic [cpu_pkg::REG_ADDR_W-1:0] wraddr,
    input logic                           whilo
);

    reset_no_write: assert property (@(posedge clk) rst |-> (!wreg && !whilo))
        else $error("write flag active during reset");

    // bubble follows a flush.
    flush_bubble: assert property (@(posedge clk) disable iff (rst)
        flush |=> (!wreg && !whilo))
        else $error("record after flush still writes");

    stall_hold: assert property (@(posedge clk) disable iff (rst)
        (stall && !flush) |=> ($stable(pc) && $stable(alures) && $stable(wreg)
                               && $stable(wraddr) && $stable(whilo)))
        else $error("record changed under stall");

endmodule

bind mem_wb_reg backend_asserts u_asserts (
    .clk    (clk),
    .rst    (rst),
    .stall  (stall),
    .flush  (flush),
    .pc     (wb_out.pc),
    .alures (wb_out.alures),
    .wreg   (wb_out.wreg),
    .wraddr (wb_out.wraddr),
    .whilo  (wb_out.whilo)
);

`default_nettype wire

/* tests/backend_golden.txt */
# I stall flush aluop pc alures storedata wreg wraddr whilo hilo   (issue, hex)
# C ra expected_rd expected_hi expected_lo expected_wb_pc         (check, hex)
C 00 00000000 00000000 00000000 00000000
C 05 00000000 00000000 00000000 00000000
I 0 0 1 00000100 12345678 00000000 1 05 0 0000000000000000
C 05 12345678 00000000 00000000 00000100
C 05 12345678 00000000 00000000 00000000
I 0 0 1 00000104 deadbeef 00000000 1 00 0 0000000000000000
C 00 00000000 00000000 00000000 00000104
I 0 0 9 00000108 00000040 a1b2c3d4 0 00 0 0000000000000000
I 0 0 6 0000010c 00000040 00000000 1 06 0 0000000000000000
C 06 a1b2c3d4 00000000 00000000 0000010c
I 0 0 2 00000110 00000043 00000000 1 07 0 0000000000000000
C 07 ffffffa1 00000000 00000000 00000110
I 0 0 3 00000114 00000042 00000000 1 08 0 0000000000000000
C 08 000000b2 00000000 00000000 00000114
I 0 0 4 00000118 00000042 00000000 1 09 0 0000000000000000
C 09 ffffa1b2 00000000 00000000 00000118
I 0 0 5 0000011c 00000040 00000000 1 0a 0 0000000000000000
C 0a 0000c3d4 00000000 00000000 0000011c
I 0 0 7 00000120 00000041 0000005e 0 00 0 0000000000000000
I 0 0 6 00000124 00000040 00000000 1 0b 0 0000000000000000
C 0b a1b25ed4 00000000 00000000 00000124
I 0 0 8 00000128 00000042 00007f01 0 00 0 0000000000000000
I 0 0 4 0000012c 00000042 00000000 1 0c 0 0000000000000000
C 0c 00007f01 00000000 00000000 0000012c
I 0 0 1 00000130 11110000 00000000 1 0d 0 0000000000000000
I 1 0 1 00000134 22220000 00000000 1 0d 0 0000000000000000
C 0d 11110000 00000000 00000000 00000130
I 0 0 1 00000134 22220000 00000000 1 0d 0 0000000000000000
C 0d 22220000 00000000 00000000 00000134
I 0 1 1 00000138 33330000 00000000 1 0e 0 0000000000000000
C 0e 00000000 00000000 00000000 00000000
I 0 1 9 0000013c 00000080 cafef00d 0 00 0 0000000000000000
I 0 0 6 00000140 00000080 00000000 1 0f 0 0000000000000000
C 0f cafef00d 00000000 00000000 00000140
I 0 0 a 00000144 00000000 00000000 0 00 1 0123456789abcdef
C 05 12345678 01234567 89abcdef 00000144
C 05 12345678 01234567 89abcdef 00000000

/* tests/tb_backend.sv */
// golden file driven testbench for backend_top with its compare and edge tasks.
`default_nettype none
`timescale 1ns/100ps

module tb_backend;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        flush;
    logic [31:0] ex_pc;
    logic [3:0]  ex_aluop;
    logic [31:0] ex_alures;
    logic [31:0] ex_storedata;
    logic        ex_wreg;
    logic [4:0]  ex_wraddr;
    logic        ex_whilo;
    logic [63:0] ex_hilo;
    logic [4:0]  ra1;
    logic [4:0]  ra2;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] wb_pc;

    int check_errors;
    int other_errors;
    int cycle_cnt;
    bit clock_stuck;

    backend_top u_backend_top (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .flush        (flush),
        .ex_pc        (ex_pc),
        .ex_aluop     (ex_aluop),
        .ex_alures    (ex_alures),
        .ex_storedata (ex_storedata),
        .ex_wreg      (ex_wreg),
        .ex_wraddr    (ex_wraddr),
        .ex_whilo     (ex_whilo),
        .ex_hilo      (ex_hilo),
        .ra1          (ra1),
        .ra2          (ra2),
        .rd1          (rd1),
        .rd2          (rd2),
        .hi           (hi),
        .lo           (lo),
        .wb_pc        (wb_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // hard limit on the whole run.
    initial begin
        #100000;
        $display("timeout: simulation did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, expected, $time);
            check_errors++;
        end
    endtask

    // waits for the next rising edge and the drive offset.
    task automatic next_edge;
        int start;
        int waited;
        start = cycle_cnt;
        waited = 0;
        while (cycle_cnt == start && waited < 100) begin
            #1;
            waited++;
        end
        if (cycle_cnt == start) begin
            $display("timeout: clock stopped advancing");
            other_errors++;
            clock_stuck = 1'b1;
        end else begin
            #1;
        end
    endtask

    task automatic drive_idle;
        stall        = 1'b0;
        flush        = 1'b0;
        ex_pc        = '0;
        ex_aluop     = 4'd0;
        ex_alures    = '0;
        ex_storedata = '0;
        ex_wreg      = 1'b0;
        ex_wraddr    = '0;
        ex_whilo     = 1'b0;
        ex_hilo      = '0;
    endtask

    initial begin
        int          fd;
        int          n;
        int          records;
        string       line;
        logic [7:0]  kind;
        logic [4:0]  c_ra;
        logic [31:0] c_rd;
        logic [31:0] c_hi;
        logic [31:0] c_lo;
        logic [31:0] c_pc;

        check_errors = 0;
        other_errors = 0;
        clock_stuck  = 1'b0;
        records      = 0;
        rst          = 1'b1;
        ra1          = '0;
        ra2          = '0;
        drive_idle();

        for (int i = 0; i < 3 && !clock_stuck; i++) begin
            next_edge();
        end
        rst = 1'b0;

        fd = $fopen("tests/backend_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file");
            other_errors++;
        end else begin
            while (!$feof(fd) && !clock_stuck) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() < 2 || line.getc(0) == "#") continue;
                kind = line.getc(0);
                if (kind == "I") begin
                    n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", kind, stall, flush,
                                ex_aluop, ex_pc, ex_alures, ex_storedata, ex_wreg,
                                ex_wraddr, ex_whilo, ex_hilo);
                    if (n != 11) begin
                        $display("malformed issue record: %s", line);
                        other_errors++;
                    end
                    records++;
                    next_edge();
                end else if (kind == "C") begin
                    n = $sscanf(line, "%c %h %h %h %h %h", kind, c_ra, c_rd, c_hi, c_lo, c_pc);
                    if (n != 6) begin
                        $display("malformed check record: %s", line);
                        other_errors++;
                    end
                    drive_idle();
                    ra1 = c_ra;
                    ra2 = c_ra;
                    #15;  // just before the next edge.
                    compare_value("rd1", {32'd0, rd1}, {32'd0, c_rd});
                    compare_value("rd2", {32'd0, rd2}, {32'd0, c_rd});
                    compare_value("hi", {32'd0, hi}, {32'd0, c_hi});
                    compare_value("lo", {32'd0, lo}, {32'd0, c_lo});
                    compare_value("wb_pc", {32'd0, wb_pc}, {32'd0, c_pc});
                    records++;
                    next_edge();
                end else begin
                    $display("unknown record kind in golden file: %s", line);
                    other_errors++;
                end
            end
            $fclose(fd);
        end

        if (records == 0) begin
            $display("golden file held no records");
            other_errors++;
        end

        $display("errors: %0d check, %0d other, over %0d records",
                 check_errors, other_errors, records);
        if (check_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/arch_regs.sv */
// arch_regs: general register file with write bypass, and the hi/lo register.
`default_nettype none
`timescale 1ns/100ps

module arch_regs (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rf_we,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rf_waddr,
    input  logic [cpu_pkg::DATA_W-1:0]     rf_wdata,
    input  logic                           hilo_we,
    input  logic [cpu_pkg::DWORD_W-1:0]    hilo_wdata,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ra1,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ra2,
    output logic [cpu_pkg::DATA_W-1:0]     rd1,
    output logic [cpu_pkg::DATA_W-1:0]     rd2,
    output logic [cpu_pkg::DATA_W-1:0]     hi,
    output logic [cpu_pkg::DATA_W-1:0]     lo
);

    logic [cpu_pkg::DATA_W-1:0] regs [2**cpu_pkg::REG_ADDR_W];
    logic [cpu_pkg::DATA_W-1:0] hi_q;
    logic [cpu_pkg::DATA_W-1:0] lo_q;
    logic                       rf_wr_ok;

    assign rf_wr_ok = rf_we && (rf_waddr != '0);  // r0 stays zero.

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**cpu_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (rf_wr_ok) begin
                regs[rf_waddr] <= rf_wdata;
            end
            if (hilo_we) begin
                hi_q <= hilo_wdata[cpu_pkg::DWORD_W-1:cpu_pkg::DATA_W];
                lo_q <= hilo_wdata[cpu_pkg::DATA_W-1:0];
            end
        end
    end

    // pending write shows on the read ports a cycle early.
    assign rd1 = (ra1 == '0)                       ? '0       :
                 (rf_wr_ok && rf_waddr == ra1)     ? rf_wdata :
                                                     regs[ra1];
    assign rd2 = (ra2 == '0)                       ? '0       :
                 (rf_wr_ok && rf_waddr == ra2)     ? rf_wdata :
                                                     regs[ra2];

    assign hi = hilo_we ? hilo_wdata[cpu_pkg::DWORD_W-1:cpu_pkg::DATA_W] : hi_q;
    assign lo = hilo_we ? hilo_wdata[cpu_pkg::DATA_W-1:0] : lo_q;

endmodule

`default_nettype wire

/* verilog/backend_top.sv */
// backend_top: memory stage, mem/wb register, write-back and architectural registers.
`default_nettype none
`timescale 1ns/100ps

module backend_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           stall,
    input  logic                           flush,
    input  logic [cpu_pkg::ADDR_W-1:0]     ex_pc,
    input  logic [cpu_pkg::ALUOP_W-1:0]    ex_aluop,
    input  logic [cpu_pkg::DATA_W-1:0]     ex_alures,
    input  logic [cpu_pkg::DATA_W-1:0]     ex_storedata,
    input  logic                           ex_wreg,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_wraddr,
    input  logic                           ex_whilo,
    input  logic [cpu_pkg::DWORD_W-1:0]    ex_hilo,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ra1,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ra2,
    output logic [cpu_pkg::DATA_W-1:0]     rd1,
    output logic [cpu_pkg::DATA_W-1:0]     rd2,
    output logic [cpu_pkg::DATA_W-1:0]     hi,
    output logic [cpu_pkg::DATA_W-1:0]     lo,
    output logic [cpu_pkg::ADDR_W-1:0]     wb_pc
);

    logic                           rf_we;
    logic [cpu_pkg::REG_ADDR_W-1:0] rf_waddr;
    logic [cpu_pkg::DATA_W-1:0]     rf_wdata;
    logic                           hilo_we;
    logic [cpu_pkg::DWORD_W-1:0]    hilo_wdata;

    mem_wb_if mem_rec ();
    mem_wb_if wb_rec ();

    mem_stage u_mem (
        .clk          (clk),
        .ex_pc        (ex_pc),
        .ex_aluop     (cpu_pkg::alu_op_e'(ex_aluop)),
        .ex_alures    (ex_alures),
        .ex_storedata (ex_storedata),
        .ex_wreg      (ex_wreg),
        .ex_wraddr    (ex_wraddr),
        .ex_whilo     (ex_whilo),
        .ex_hilo      (ex_hilo),
        .mem_out      (mem_rec)
    );

    mem_wb_reg u_mem_wb (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (flush),
        .mem_in (mem_rec),
        .wb_out (wb_rec)
    );

    wb_stage u_wb (
        .wb_in      (wb_rec),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .hilo_we    (hilo_we),
        .hilo_wdata (hilo_wdata)
    );

    arch_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .hilo_we    (hilo_we),
        .hilo_wdata (hilo_wdata),
        .ra1        (ra1),
        .ra2        (ra2),
        .rd1        (rd1),
        .rd2        (rd2),
        .hi         (hi),
        .lo         (lo)
    );

    assign wb_pc = wb_rec.pc;  // retiring pc, for exception reporting.

endmodule

`default_nettype wire

/* verilog/cpu_pkg.sv */
// cpu_pkg: data path widths, data ram depth and the alu operation enum.
`default_nettype none

package cpu_pkg;

    localparam int ADDR_W     = 32;  // instruction and data address.
    localparam int DATA_W     = 32;
    localparam int DWORD_W    = 64;  // hi/lo pair.
    localparam int REG_ADDR_W = 5;
    localparam int ALUOP_W    = 4;

    // data ram, word indexed by address bits 9 down to 2.
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // operation carried down the pipe.
    // encodings are fixed, the golden file uses the raw values.
    typedef enum logic [ALUOP_W-1:0] {
        ALU_NOP   = 4'd0,
        ALU_ARITH = 4'd1,   // result is the alu value.
        ALU_LB    = 4'd2,
        ALU_LBU   = 4'd3,
        ALU_LH    = 4'd4,
        ALU_LHU   = 4'd5,
        ALU_LW    = 4'd6,
        ALU_SB    = 4'd7,
        ALU_SH    = 4'd8,
        ALU_SW    = 4'd9,
        ALU_MULT  = 4'd10   // writes hi/lo.
    } alu_op_e;

endpackage

`default_nettype wire

/* verilog/mem_stage.sv */
// mem_stage: data ram with byte lane stores and word reads, builds the mem record.
`default_nettype none
`timescale 1ns/100ps

module mem_stage (
    input  logic                           clk,
    input  logic [cpu_pkg::ADDR_W-1:0]     ex_pc,
    input  cpu_pkg::alu_op_e               ex_aluop,
    input  logic [cpu_pkg::DATA_W-1:0]     ex_alures,
    input  logic [cpu_pkg::DATA_W-1:0]     ex_storedata,
    input  logic                           ex_wreg,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_wraddr,
    input  logic                           ex_whilo,
    input  logic [cpu_pkg::DWORD_W-1:0]    ex_hilo,
    mem_wb_if.src                          mem_out
);

    logic [cpu_pkg::DATA_W-1:0]  ram [cpu_pkg::DMEM_WORDS];
    logic [cpu_pkg::DMEM_AW-1:0] word_idx;
    logic [3:0]                  lane_en;
    logic [cpu_pkg::DATA_W-1:0]  st_data;

    assign word_idx = ex_alures[cpu_pkg::DMEM_AW+1:2];

    // lane enables and replicated store data.
    always_comb begin
        lane_en = 4'b0000;
        st_data = ex_storedata;
        case (ex_aluop)
            cpu_pkg::ALU_SB: begin
                lane_en = 4'b0001 << ex_alures[1:0];
                st_data = {4{ex_storedata[7:0]}};
            end
            cpu_pkg::ALU_SH: begin
                lane_en = ex_alures[1] ? 4'b1100 : 4'b0011;
                st_data = {2{ex_storedata[15:0]}};
            end
            cpu_pkg::ALU_SW: begin
                lane_en = 4'b1111;
            end
            default: begin
                lane_en = 4'b0000;  // no store.
            end
        endcase
    end

    // store lands at the edge closing its cycle.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (lane_en[i]) begin
                ram[word_idx][8*i +: 8] <= st_data[8*i +: 8];
            end
        end
    end

    // load word is combinational, alignment happens in write-back.
    assign mem_out.memdata = ram[word_idx];

    assign mem_out.pc     = ex_pc;
    assign mem_out.aluop  = ex_aluop;
    assign mem_out.alures = ex_alures;
    assign mem_out.wreg   = ex_wreg;
    assign mem_out.wraddr = ex_wraddr;
    assign mem_out.whilo  = ex_whilo;
    assign mem_out.hilo   = ex_hilo;

endmodule

`default_nettype wire

/* verilog/mem_wb_if.sv */
// mem_wb_if: one mem/wb pipeline record with source and sink modports.
`default_nettype none
`timescale 1ns/100ps

interface mem_wb_if;

    logic [cpu_pkg::ADDR_W-1:0]     pc;
    cpu_pkg::alu_op_e               aluop;
    logic [cpu_pkg::DATA_W-1:0]     alures;   // alu value or effective address.
    logic [cpu_pkg::DATA_W-1:0]     memdata;  // raw ram word.
    logic                           wreg;
    logic [cpu_pkg::REG_ADDR_W-1:0] wraddr;
    logic                           whilo;
    logic [cpu_pkg::DWORD_W-1:0]    hilo;

    modport src (
        output pc, aluop, alures, memdata, wreg, wraddr, whilo, hilo
    );

    modport dst (
        input pc, aluop, alures, memdata, wreg, wraddr, whilo, hilo
    );

endinterface

`default_nettype wire

/* verilog/mem_wb_reg.sv */
// mem_wb_reg: mem/wb pipeline register with stall hold and flush bubble.
`default_nettype none
`timescale 1ns/100ps

module mem_wb_reg (
    input  logic   clk,
    input  logic   rst,
    input  logic   stall,
    input  logic   flush,
    mem_wb_if.dst  mem_in,
    mem_wb_if.src  wb_out
);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wb_out.pc      <= '0;
            wb_out.aluop   <= cpu_pkg::ALU_NOP;
            wb_out.alures  <= '0;
            wb_out.memdata <= '0;
            wb_out.wreg    <= 1'b0;
            wb_out.wraddr  <= '0;
            wb_out.whilo   <= 1'b0;
            wb_out.hilo    <= '0;
        end else if (flush) begin
            // bubble wins over stall.
            wb_out.pc      <= '0;
            wb_out.aluop   <= cpu_pkg::ALU_NOP;
            wb_out.alures  <= '0;
            wb_out.memdata <= '0;
            wb_out.wreg    <= 1'b0;
            wb_out.wraddr  <= '0;
            wb_out.whilo   <= 1'b0;
            wb_out.hilo    <= '0;
        end else if (!stall) begin
            wb_out.pc      <= mem_in.pc;
            wb_out.aluop   <= mem_in.aluop;
            wb_out.alures  <= mem_in.alures;
            wb_out.memdata <= mem_in.memdata;
            wb_out.wreg    <= mem_in.wreg;
            wb_out.wraddr  <= mem_in.wraddr;
            wb_out.whilo   <= mem_in.whilo;
            wb_out.hilo    <= mem_in.hilo;
        end
        // stall: hold.
    end

endmodule

`default_nettype wire

/* verilog/wb_stage.sv */
// wb_stage: load alignment and extension, register file and hi/lo write ports.
`default_nettype none
`timescale 1ns/100ps

module wb_stage (
    mem_wb_if.dst                          wb_in,
    output logic                           rf_we,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rf_waddr,
    output logic [cpu_pkg::DATA_W-1:0]     rf_wdata,
    output logic                           hilo_we,
    output logic [cpu_pkg::DWORD_W-1:0]    hilo_wdata
);

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // little endian lanes, same as the store side.
    assign ld_byte = wb_in.memdata[8*wb_in.alures[1:0] +: 8];
    assign ld_half = wb_in.alures[1] ? wb_in.memdata[31:16] : wb_in.memdata[15:0];

    always_comb begin
        case (wb_in.aluop)
            cpu_pkg::ALU_LB:  rf_wdata = {{24{ld_byte[7]}}, ld_byte};
            cpu_pkg::ALU_LBU: rf_wdata = {24'd0, ld_byte};
            cpu_pkg::ALU_LH:  rf_wdata = {{16{ld_half[15]}}, ld_half};
            cpu_pkg::ALU_LHU: rf_wdata = {16'd0, ld_half};
            cpu_pkg::ALU_LW:  rf_wdata = wb_in.memdata;
            default:          rf_wdata = wb_in.alures;
        endcase
    end

    assign rf_we    = wb_in.wreg;
    assign rf_waddr = wb_in.wraddr;

    assign hilo_we    = wb_in.whilo;
    assign hilo_wdata = wb_in.hilo;  // hi in the upper half.

endmodule

`default_nettype wire
